// File: Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f fp_divider.f --top-module fp_divider

sim:
	verilator --binary --timing -Wno-fatal -f fp_divider.f --top-module fp_divider_tb \
		-Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vfp_divider_tb | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/fp_div_vectors.txt
// columns: a  b  expected_result  expected_flags  class
// flags nv dz of uf nx on bits 4..0, class 0 ordinary, 1 special, f ends the list
// exact quotients
40c00000 3f800000 40c00000 00 0
3f800000 3f800000 3f800000 00 0
c1100000 40400000 c0400000 00 0
3f800000 40800000 3e800000 00 0
40e00000 40000000 40600000 00 0
41200000 40800000 40200000 00 0
40c00000 40000000 40400000 00 0
7f7fffff 3f800000 7f7fffff 00 0
01000000 40000000 00800000 00 0
// inexact, 1/3 has guard set, round clear, even lsb, sticky decides
3f800000 40400000 3eaaaaab 01 0
40000000 40400000 3f2aaaab 01 0
3f800000 41200000 3dcccccd 01 0
3f800000 40e00000 3e124925 01 0
40a00000 40400000 3fd55555 01 0
bf800000 40400000 beaaaaab 01 0
// overflow and underflow
7f000000 3f000000 7f800000 05 0
ff000000 3f000000 ff800000 05 0
7f7fffff 00800000 7f800000 05 0
00800000 40000000 00000000 03 0
80800000 40000000 80000000 03 0
01000000 7f000000 00000000 03 0
// nan operands and invalid cases
ffc12345 3f800000 7fc00000 00 1
7f800001 3f800000 7fc00000 10 1
3f800000 7fa00000 7fc00000 10 1
00000000 00000000 7fc00000 10 1
7f800000 ff800000 7fc00000 10 1
// divide by zero and infinite dividend
3f800000 00000000 7f800000 08 1
c0000000 00000000 ff800000 08 1
3f800000 80000000 ff800000 08 1
7f800000 40000000 7f800000 00 1
ff800000 00000000 ff800000 00 1
// zero results, subnormals count as zero
00000000 40a00000 00000000 00 1
80000000 40400000 80000000 00 1
40400000 7f800000 00000000 00 1
40400000 ff800000 80000000 00 1
00400000 3f800000 00000000 00 1
3f800000 00000001 7f800000 08 1
00000000 00000000 00000000 00 f

// File: dv/fp_divider_tb.sv
`timescale 1ns/1ps

module fp_divider_tb;

    localparam int MAX_VEC      = 64;
    localparam int FIELDS       = 5;      // a, b, result, flags, class
    localparam int RESET_CYCLES = 4;
    localparam int LAT_ORDINARY = 28;
    localparam int LAT_SPECIAL  = 2;
    localparam int WAIT_LIMIT   = 40;     // cycles allowed per operation
    localparam logic [31:0] END_MARK = 32'hf;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [31:0] a;
    logic [31:0] b;
    logic        busy;
    logic        done;
    logic [31:0] result;
    logic [4:0]  fflags;

    logic [31:0] vec_mem [0:MAX_VEC*FIELDS-1];
    int          num_vec;
    bit          loaded;
    int          errors;
    int          tests;
    int          failed_tests;

    fp_divider u_fp_divider (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .done   (done),
        .result (result),
        .fflags (fflags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string label, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, label);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAILED", tests, label);
        end
    endtask

    // called on a falling edge, lat counts rising edges after the sampled start
    task automatic run_op(input logic [31:0] op_a, input logic [31:0] op_b,
                          output int lat, output bit got_done);
        lat      = 0;
        got_done = 1'b0;
        start    = 1'b1;
        a        = op_a;
        b        = op_b;
        @(negedge clk);       // edge 0 is behind us
        start = 1'b0;
        while (!done && lat < WAIT_LIMIT) begin
            check_value("busy", {31'b0, busy}, 32'd1);
            @(negedge clk);
            lat++;
        end
        got_done = done;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("busy still high %0d cycles after done", WAIT_LIMIT);
            errors++;
        end
    endtask

    // second start lands while busy, only the first operation may complete
    task automatic ignored_start_test();
        int cyc;
        int done_count;
        int err_before;
        err_before = errors;
        cyc        = 0;
        done_count = 0;
        start      = 1'b1;
        a          = vec_mem[0];
        b          = vec_mem[1];
        @(negedge clk);
        start = 1'b0;
        repeat (3) begin
            @(negedge clk);
            cyc++;
        end
        check_value("busy", {31'b0, busy}, 32'd1);
        start = 1'b1;
        a     = vec_mem[FIELDS];
        b     = vec_mem[FIELDS+1];
        while (cyc < 2 * WAIT_LIMIT) begin
            @(negedge clk);
            cyc++;
            start = 1'b0;
            if (done) begin
                done_count++;
                if (done_count == 1) begin
                    check_value("result", result, vec_mem[2]);
                    check_value("fflags", {27'b0, fflags}, vec_mem[3]);
                    check_value("latency", cyc, LAT_ORDINARY);
                end
            end
        end
        if (done_count != 1) begin
            $display("expected one done pulse for two starts, saw %0d", done_count);
            errors++;
        end
        report_test("start while busy", err_before);
    endtask

    initial begin
        int          lat;
        bit          got_done;
        int          err_before;
        logic [31:0] exp_lat;
        rst_n        = 1'b0;
        start        = 1'b0;
        a            = '0;
        b            = '0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        num_vec      = 0;
        $readmemh("dv/fp_div_vectors.txt", vec_mem);
        while (num_vec < MAX_VEC && vec_mem[num_vec*FIELDS+4] != END_MARK) begin
            num_vec++;
        end
        if (num_vec == 0 || num_vec == MAX_VEC) begin
            $display("vector file unreadable or missing its end marker");
            errors++;
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        err_before = errors;
        check_value("done", {31'b0, done}, 32'd0);
        check_value("busy", {31'b0, busy}, 32'd0);
        check_value("result", result, 32'd0);
        check_value("fflags", {27'b0, fflags}, 32'd0);
        report_test("reset state", err_before);
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < num_vec && num_vec < MAX_VEC; i++) begin
            err_before = errors;
            exp_lat = (vec_mem[i*FIELDS+4] == 1) ? LAT_SPECIAL : LAT_ORDINARY;
            run_op(vec_mem[i*FIELDS], vec_mem[i*FIELDS+1], lat, got_done);
            if (!got_done) begin
                $display("no done pulse within %0d cycles of start", WAIT_LIMIT);
                errors++;
            end else begin
                check_value("result", result, vec_mem[i*FIELDS+2]);
                check_value("fflags", {27'b0, fflags}, vec_mem[i*FIELDS+3]);
                check_value("latency", lat, exp_lat);
            end
            wait_idle();
            report_test($sformatf("%h / %h", vec_mem[i*FIELDS], vec_mem[i*FIELDS+1]),
                        err_before);
        end

        if (num_vec > 1 && num_vec < MAX_VEC) begin
            ignored_start_test();
        end

        $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + (num_vec + 2) * WAIT_LIMIT) @(posedge clk);
        $display("timeout: run did not finish within the expected number of cycles");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: fp_divider.f
src/fp_div_pkg.sv
src/fp_operand_decode.sv
src/mantissa_divider.sv
src/fp_div_round.sv
src/fp_divider.sv
dv/fp_divider_tb.sv

// File: src/fp_div_pkg.sv
package fp_div_pkg;

    // binary32 layout
    localparam int FLEN       = 32;
    localparam int EXPO_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int MANT_WIDTH = FRAC_WIDTH + 1;      // hidden bit included

    // biased exponent difference carries a sign and an overflow bit
    localparam int EXPO_DIFF_WIDTH = EXPO_WIDTH + 2;

    localparam logic [EXPO_DIFF_WIDTH-1:0] BIAS     = 127;
    localparam logic [EXPO_WIDTH-1:0]      EXPO_MAX = '1;   // inf / nan exponent

    // integer bit, fraction, guard and round
    localparam int QUOT_WIDTH    = FRAC_WIDTH + 3;
    localparam int DIV_CYCLES    = QUOT_WIDTH;
    localparam int DIV_CNT_WIDTH = $clog2(DIV_CYCLES);

    // positive quiet nan, top fraction bit only
    localparam logic [FLEN-1:0] CANONICAL_NAN = 32'h7fc0_0000;

    // exception flag word
    localparam int FLAG_WIDTH = 5;
    localparam int FLAG_NV    = 4;
    localparam int FLAG_DZ    = 3;
    localparam int FLAG_OF    = 2;
    localparam int FLAG_UF    = 1;
    localparam int FLAG_NX    = 0;

    typedef struct packed {
        logic                  sign;
        logic [EXPO_WIDTH-1:0] expo;
        logic [FRAC_WIDTH-1:0] frac;
    } fp32_fields_t;

    // same word, seen either as raw bits or as its fields
    typedef union packed {
        logic [FLEN-1:0] raw;
        fp32_fields_t    fields;
    } fp32_word_u;

endpackage

// File: src/fp_div_round.sv
`timescale 1ns/1ps

module fp_div_round (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    quot_valid,
    input  logic [fp_div_pkg::QUOT_WIDTH-1:0]       quotient,
    input  logic                                    sticky,
    input  logic                                    sign,
    input  logic [fp_div_pkg::EXPO_DIFF_WIDTH-1:0]  expo_diff,
    input  logic                                    special_valid,
    input  logic [fp_div_pkg::FLEN-1:0]             special_result,
    input  logic                                    invalid,
    input  logic                                    div_by_zero,
    output logic                                    done,
    output logic [fp_div_pkg::FLEN-1:0]             result,
    output logic [fp_div_pkg::FLAG_WIDTH-1:0]       fflags
);

    localparam int QW = fp_div_pkg::QUOT_WIDTH;
    localparam int MW = fp_div_pkg::MANT_WIDTH;
    localparam int EW = fp_div_pkg::EXPO_DIFF_WIDTH;

    logic [MW-1:0]  mant;
    logic [MW:0]    mant_rnd;
    logic [EW-1:0]  expo_norm, expo_final;
    logic           guard_bit, round_bit;
    logic           round_up, carry, inexact;
    logic           oflow, uflow;
    logic [fp_div_pkg::FRAC_WIDTH-1:0] frac;
    fp_div_pkg::fp32_word_u            packed_word;
    logic [fp_div_pkg::FLAG_WIDTH-1:0] flags;

    // quotient lies in (0.5, 2), so at most one left shift
    always_comb begin
        if (quotient[QW-1]) begin
            mant      = quotient[QW-1:2];
            guard_bit = quotient[1];
            round_bit = quotient[0];
            expo_norm = expo_diff;
        end else begin
            mant      = quotient[QW-2:1];
            guard_bit = quotient[0];
            round_bit = 1'b0;
            expo_norm = expo_diff - 1'b1;
        end
    end

    // nearest even
    assign inexact  = guard_bit | round_bit | sticky;
    assign round_up = guard_bit & (round_bit | sticky | mant[0]);
    assign mant_rnd = {1'b0, mant} + round_up;
    assign carry    = mant_rnd[MW];                   // 1.111.. rounded up to 10.000..
    assign frac     = carry ? mant_rnd[MW-1:1] : mant_rnd[MW-2:0];
    assign expo_final = expo_norm + carry;

    // two's complement exponent checks
    assign uflow = expo_final[EW-1] | (expo_final == '0);
    assign oflow = ~expo_final[EW-1] & (expo_final[EW-2:0] >= {1'b0, fp_div_pkg::EXPO_MAX});

    always_comb begin
        flags = '0;
        if (oflow) begin
            packed_word.fields = '{sign: sign, expo: fp_div_pkg::EXPO_MAX, frac: '0};
            flags[fp_div_pkg::FLAG_OF] = 1'b1;
            flags[fp_div_pkg::FLAG_NX] = 1'b1;
        end else if (uflow) begin
            packed_word.fields = '{sign: sign, expo: '0, frac: '0};   // flush to zero
            flags[fp_div_pkg::FLAG_UF] = 1'b1;
            flags[fp_div_pkg::FLAG_NX] = 1'b1;
        end else begin
            packed_word.fields = '{sign: sign,
                                   expo: expo_final[fp_div_pkg::EXPO_WIDTH-1:0],
                                   frac: frac};
            flags[fp_div_pkg::FLAG_NX] = inexact;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
            fflags <= '0;
        end else begin
            done <= quot_valid | special_valid;
            if (special_valid) begin
                result <= special_result;
                fflags <= '0;
                fflags[fp_div_pkg::FLAG_NV] <= invalid;
                fflags[fp_div_pkg::FLAG_DZ] <= div_by_zero;
            end else if (quot_valid) begin
                result <= packed_word.raw;
                fflags <= flags;
            end
        end
    end

endmodule

// File: src/fp_divider.sv
`timescale 1ns/1ps

module fp_divider (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [fp_div_pkg::FLEN-1:0]         a,
    input  logic [fp_div_pkg::FLEN-1:0]         b,
    output logic                                busy,
    output logic                                done,
    output logic [fp_div_pkg::FLEN-1:0]         result,
    output logic [fp_div_pkg::FLAG_WIDTH-1:0]   fflags
);

    logic                                   accept;
    logic                                   dec_valid, special;
    logic                                   div_start, special_valid;
    logic [fp_div_pkg::FLEN-1:0]            special_result;
    logic                                   invalid, div_by_zero, sign;
    logic [fp_div_pkg::EXPO_DIFF_WIDTH-1:0] expo_diff;
    logic [fp_div_pkg::MANT_WIDTH-1:0]      dividend_mant, divisor_mant;
    logic [fp_div_pkg::QUOT_WIDTH-1:0]      quotient;
    logic                                   sticky, div_done;

    assign accept = start & ~busy;   // starts while busy are dropped

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end
    end

    // special cases skip the divider
    assign div_start     = dec_valid & ~special;
    assign special_valid = dec_valid & special;

    fp_operand_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (accept),
        .a              (a),
        .b              (b),
        .dec_valid      (dec_valid),
        .special        (special),
        .special_result (special_result),
        .invalid        (invalid),
        .div_by_zero    (div_by_zero),
        .sign           (sign),
        .expo_diff      (expo_diff),
        .dividend_mant  (dividend_mant),
        .divisor_mant   (divisor_mant)
    );

    mantissa_divider u_divider (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (div_start),
        .dividend_mant  (dividend_mant),
        .divisor_mant   (divisor_mant),
        .quotient       (quotient),
        .sticky         (sticky),
        .div_done       (div_done)
    );

    fp_div_round u_round (
        .clk            (clk),
        .rst_n          (rst_n),
        .quot_valid     (div_done),
        .quotient       (quotient),
        .sticky         (sticky),
        .sign           (sign),
        .expo_diff      (expo_diff),
        .special_valid  (special_valid),
        .special_result (special_result),
        .invalid        (invalid),
        .div_by_zero    (div_by_zero),
        .done           (done),
        .result         (result),
        .fflags         (fflags)
    );

endmodule

// File: src/fp_operand_decode.sv
`timescale 1ns/1ps

module fp_operand_decode (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  logic [fp_div_pkg::FLEN-1:0]             a,
    input  logic [fp_div_pkg::FLEN-1:0]             b,
    output logic                                    dec_valid,
    output logic                                    special,
    output logic [fp_div_pkg::FLEN-1:0]             special_result,
    output logic                                    invalid,
    output logic                                    div_by_zero,
    output logic                                    sign,
    output logic [fp_div_pkg::EXPO_DIFF_WIDTH-1:0]  expo_diff,
    output logic [fp_div_pkg::MANT_WIDTH-1:0]       dividend_mant,
    output logic [fp_div_pkg::MANT_WIDTH-1:0]       divisor_mant
);

    fp_div_pkg::fp32_word_u a_q, b_q;
    fp_div_pkg::fp32_word_u spec_word;
    logic start_q;
    logic a_zero, a_inf, a_nan, a_snan;
    logic b_zero, b_inf, b_nan, b_snan;
    logic is_invalid, is_dz, out_nan, out_inf, out_zero;
    logic res_sign;

    // operand capture at the accepted start
    always_ff @(posedge clk) begin
        if (start) begin
            a_q.raw <= a;
            b_q.raw <= b;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_q   <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            start_q   <= start;
            dec_valid <= start_q;
        end
    end

    // zero exponent means zero, subnormals are flushed
    assign a_zero = (a_q.fields.expo == '0);
    assign b_zero = (b_q.fields.expo == '0);
    assign a_inf  = (a_q.fields.expo == fp_div_pkg::EXPO_MAX) && (a_q.fields.frac == '0);
    assign b_inf  = (b_q.fields.expo == fp_div_pkg::EXPO_MAX) && (b_q.fields.frac == '0);
    assign a_nan  = (a_q.fields.expo == fp_div_pkg::EXPO_MAX) && (a_q.fields.frac != '0);
    assign b_nan  = (b_q.fields.expo == fp_div_pkg::EXPO_MAX) && (b_q.fields.frac != '0);
    assign a_snan = a_nan & ~a_q.fields.frac[fp_div_pkg::FRAC_WIDTH-1];  // quiet bit clear
    assign b_snan = b_nan & ~b_q.fields.frac[fp_div_pkg::FRAC_WIDTH-1];

    assign res_sign   = a_q.fields.sign ^ b_q.fields.sign;
    assign is_invalid = (a_zero & b_zero) | (a_inf & b_inf) | a_snan | b_snan;
    assign is_dz      = ~a_zero & ~a_inf & ~a_nan & b_zero;  // finite nonzero over zero
    assign out_nan    = is_invalid | a_nan | b_nan;
    assign out_inf    = ~out_nan & (b_zero | a_inf);
    assign out_zero   = ~out_nan & (a_zero | b_inf);

    always_comb begin
        if (out_nan) begin
            spec_word.raw = fp_div_pkg::CANONICAL_NAN;
        end else if (out_inf) begin
            spec_word.fields = '{sign: res_sign, expo: fp_div_pkg::EXPO_MAX, frac: '0};
        end else begin
            spec_word.fields = '{sign: res_sign, expo: '0, frac: '0};  // signed zero
        end
    end

    // held from dec_valid until the next start
    always_ff @(posedge clk) begin
        if (start_q) begin
            special        <= out_nan | out_inf | out_zero;
            special_result <= spec_word.raw;
            invalid        <= is_invalid;
            div_by_zero    <= is_dz;
            sign           <= res_sign;
            expo_diff      <= {2'b00, a_q.fields.expo} - {2'b00, b_q.fields.expo}
                              + fp_div_pkg::BIAS;
            dividend_mant  <= {1'b1, a_q.fields.frac};
            divisor_mant   <= {1'b1, b_q.fields.frac};
        end
    end

endmodule

// File: src/mantissa_divider.sv
`timescale 1ns/1ps

module mantissa_divider (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [fp_div_pkg::MANT_WIDTH-1:0]   dividend_mant,
    input  logic [fp_div_pkg::MANT_WIDTH-1:0]   divisor_mant,
    output logic [fp_div_pkg::QUOT_WIDTH-1:0]   quotient,
    output logic                                sticky,
    output logic                                div_done
);

    // partial remainder stays below twice the divisor
    logic [fp_div_pkg::MANT_WIDTH:0]     rem_q, rem_in, rem_next;
    logic [fp_div_pkg::MANT_WIDTH-1:0]   divisor_q, div_in;
    logic [fp_div_pkg::MANT_WIDTH+1:0]   diff;
    logic [fp_div_pkg::DIV_CNT_WIDTH-1:0] cnt;
    logic                                running;
    logic                                q_bit;

    // first bit is taken on the load edge itself
    assign rem_in = start ? {1'b0, dividend_mant} : rem_q;
    assign div_in = start ? divisor_mant : divisor_q;

    assign diff     = {1'b0, rem_in} - {2'b00, div_in};
    assign q_bit    = ~diff[fp_div_pkg::MANT_WIDTH+1];        // no borrow
    assign rem_next = q_bit ? diff[fp_div_pkg::MANT_WIDTH:0] : rem_in;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= fp_div_pkg::DIV_CNT_WIDTH'(fp_div_pkg::DIV_CYCLES - 1);
            end else if (running) begin
                cnt <= cnt - 1'b1;
                if (cnt == 1) begin
                    running  <= 1'b0;   // last quotient bit this edge
                    div_done <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            divisor_q <= divisor_mant;
            quotient  <= {{(fp_div_pkg::QUOT_WIDTH-1){1'b0}}, q_bit};
            rem_q     <= {rem_next[fp_div_pkg::MANT_WIDTH-1:0], 1'b0};
        end else if (running) begin
            quotient <= {quotient[fp_div_pkg::QUOT_WIDTH-2:0], q_bit};
            rem_q    <= {rem_next[fp_div_pkg::MANT_WIDTH-1:0], 1'b0};
        end
    end

    // anything left over means the quotient is inexact
    assign sticky = |rem_q;

endmodule
